/* sources.f */
source/tetris_ai_pkg.sv
source/placement_engine.sv
source/feature_extract.sv
source/q_scorer.sv
source/argmax_unit.sv
source/ai_move_select.sv
testbench/ai_move_select_chk.sv
testbench/ai_move_select_tb.sv

/* Bender.yml */
package:
  name: tetris_ai

sources:
  - source/tetris_ai_pkg.sv
  - source/placement_engine.sv
  - source/feature_extract.sv
  - source/q_scorer.sv
  - source/argmax_unit.sv
  - source/ai_move_select.sv
  - target: test
    files:
      - testbench/ai_move_select_chk.sv
      - testbench/ai_move_select_tb.sv

/* testbench/ai_move_select_tb.sv */
module ai_move_select_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int max_runs   = 12;
  localparam int max_cycles = max_runs * 1844 + 500;  // Worst case per run plus gaps

  logic                                     clk;
  logic                                     reset_n;
  logic                                     start_ai;
  logic [tetris_ai_pkg::board_bits-1:0]     display_array;
  logic [2:0]                               piece_type;
  logic [tetris_ai_pkg::move_id_width-1:0]  best_move_id;
  logic signed [tetris_ai_pkg::q_width-1:0] best_q_value;
  logic                                     found;
  logic                                     done_ai;

  // Expected result, read by the bound checker
  logic                                     check_en;
  logic                                     exp_found;
  logic [tetris_ai_pkg::move_id_width-1:0]  exp_move_id;
  logic signed [tetris_ai_pkg::q_width-1:0] exp_q_value;

  logic                                     last_found;
  logic [tetris_ai_pkg::move_id_width-1:0]  last_move_id;
  logic signed [tetris_ai_pkg::q_width-1:0] last_q_value;
  logic [15:0]                              lfsr_q = 16'd16613;
  int                                       run_count = 0;
  int                                       cycle_count = 0;

  ai_move_select i_ai_move_select (
    .clk           (clk),
    .reset_n       (reset_n),
    .start_ai      (start_ai),
    .display_array (display_array),
    .piece_type    (piece_type),
    .best_move_id  (best_move_id),
    .best_q_value  (best_q_value),
    .found         (found),
    .done_ai       (done_ai)
  );

  bind ai_move_select ai_move_select_chk i_ai_move_select_chk (
    .clk          (clk),
    .reset_n      (reset_n),
    .start_ai     (start_ai),
    .done_ai      (done_ai),
    .found        (found),
    .best_move_id (best_move_id),
    .best_q_value (best_q_value),
    .check_en     (ai_move_select_tb.check_en),
    .exp_found    (ai_move_select_tb.exp_found),
    .exp_move_id  (ai_move_select_tb.exp_move_id),
    .exp_q_value  (ai_move_select_tb.exp_q_value)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int random_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = (v << 1) | lfsr_q[0];
    end
    return v;
  endfunction

  // Random fill of rows 14 to 19, upper rows stay empty
  function automatic logic [tetris_ai_pkg::board_bits-1:0] random_board();
    logic [tetris_ai_pkg::board_bits-1:0] b;
    b = '0;
    for (int i = 140; i < 200; i++) begin
      b[i] = (random_bits(1) == 1);
    end
    return b;
  endfunction

  function automatic logic signed [17:0] linear_score(input int lines, input int holes,
                                                      input int bump, input int hsum);
    return 18'(8 * lines - 4 * holes - bump - 2 * hsum);
  endfunction

  task automatic expect_result(input logic f, input logic [5:0] id,
                               input logic signed [17:0] q);
    exp_found   = f;
    exp_move_id = id;
    exp_q_value = q;
    check_en    = 1'b1;
  endtask

  task automatic run_move_select(input logic [tetris_ai_pkg::board_bits-1:0] board,
                                 input logic [2:0] piece, input logic poke_busy);
    display_array = board;
    piece_type    = piece;
    start_ai      = 1'b1;
    @(negedge clk);
    start_ai = 1'b0;
    if (poke_busy) begin    // Second start mid-run must be ignored
      repeat (40) @(negedge clk);
      display_array = '1;
      start_ai      = 1'b1;
      @(negedge clk);
      start_ai = 1'b0;
    end
    while (!done_ai) @(negedge clk);
    last_found   = found;
    last_move_id = best_move_id;
    last_q_value = best_q_value;
    run_count++;
    repeat (4) @(negedge clk);
  endtask

  initial begin : watchdog
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, done_ai never arrived", cycle_count);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [tetris_ai_pkg::board_bits-1:0] board;
    logic [2:0]                           piece;
    int                                   errors;
    reset_n       = 1'b0;
    start_ai      = 1'b0;
    display_array = '0;
    piece_type    = '0;
    check_en      = 1'b0;
    exp_found     = 1'b0;
    exp_move_id   = '0;
    exp_q_value   = '0;
    repeat (10) @(negedge clk);
    reset_n = 1'b1;
    repeat (2) @(negedge clk);

    // Empty board, flat bar at column 0 wins the tie with column 6
    expect_result(1'b1, 6'd0, linear_score(0, 0, 1, 4));
    run_move_select('0, 3'd0, 1'b1);

    // Row 19 open at columns 0 to 3
    board = '0;
    for (int c = 4; c < 10; c++) begin
      board[19 * 10 + c] = 1'b1;
    end
    expect_result(1'b1, 6'd0, linear_score(1, 0, 0, 10));
    run_move_select(board, 3'd0, 1'b0);

    // Rows 0 and 1 full, nothing spawns
    board        = '0;
    board[19:0]  = '1;
    expect_result(1'b0, 6'd63, 18'sh20000);
    run_move_select(board, 3'd3, 1'b0);

    for (int n = 0; n < 4; n++) begin
      board    = random_board();
      piece    = 3'(random_bits(3) % 7);
      check_en = 1'b0;    // Range check only
      run_move_select(board, piece, 1'b0);
      expect_result(last_found, last_move_id, last_q_value);
      run_move_select(board, piece, 1'b0);
    end

    errors = i_ai_move_select.i_ai_move_select_chk.fail_count;
    $display("Runs: %0d, failed checks: %0d", run_count, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* testbench/ai_move_select_chk.sv */
module ai_move_select_chk (
  input logic                                     clk,
  input logic                                     reset_n,
  input logic                                     start_ai,
  input logic                                     done_ai,
  input logic                                     found,
  input logic [tetris_ai_pkg::move_id_width-1:0]  best_move_id,
  input logic signed [tetris_ai_pkg::q_width-1:0] best_q_value,
  input logic                                     check_en,
  input logic                                     exp_found,
  input logic [tetris_ai_pkg::move_id_width-1:0]  exp_move_id,
  input logic signed [tetris_ai_pkg::q_width-1:0] exp_q_value
);

  timeunit 1ns;
  timeprecision 1ps;

  int   fail_count = 0;
  logic pending_q;      // A run was accepted and has not finished
  int   wait_q;         // Cycles spent in the open run

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pending_q <= 1'b0;
      wait_q    <= 0;
    end else if (start_ai && (!pending_q || done_ai)) begin
      pending_q <= 1'b1;
      wait_q    <= 0;
    end else if (done_ai) begin
      pending_q <= 1'b0;
    end else if (pending_q) begin
      wait_q <= wait_q + 1;
    end
  end

  // ------------------------------------------------------------------
  // Result against the expected registers
  // ------------------------------------------------------------------
  a_found: assert property (@(posedge clk) disable iff (!reset_n)
    done_ai && check_en |-> found == exp_found)
    else begin
      fail_count++;
      $error("[ERROR] found: expected %h, got %h", $sampled(exp_found), $sampled(found));
    end

  a_move_id: assert property (@(posedge clk) disable iff (!reset_n)
    done_ai && check_en |-> best_move_id == exp_move_id)
    else begin
      fail_count++;
      $error("[ERROR] best_move_id: expected %h, got %h",
             $sampled(exp_move_id), $sampled(best_move_id));
    end

  a_q_value: assert property (@(posedge clk) disable iff (!reset_n)
    done_ai && check_en |-> best_q_value == exp_q_value)
    else begin
      fail_count++;
      $error("[ERROR] best_q_value: expected %h, got %h",
             $sampled(exp_q_value), $sampled(best_q_value));
    end

  // 40 candidates, ids 0 to 39
  a_range: assert property (@(posedge clk) disable iff (!reset_n)
    done_ai && found |-> best_move_id < 6'd40)
    else begin
      fail_count++;
      $error("[ERROR] best_move_id: out of range, got %h", $sampled(best_move_id));
    end

  // ------------------------------------------------------------------
  // Protocol
  // ------------------------------------------------------------------
  a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    done_ai |=> !done_ai)
    else begin
      fail_count++;
      $error("done_ai stayed high for more than one cycle");
    end

  a_done_owned: assert property (@(posedge clk) disable iff (!reset_n)
    done_ai |-> pending_q)
    else begin
      fail_count++;
      $error("done_ai came without an accepted start_ai");
    end

  a_latency: assert property (@(posedge clk) disable iff (!reset_n)
    pending_q |-> wait_q <= 1844)
    else begin
      fail_count++;
      $error("done_ai missing 1844 cycles after start_ai");
    end

  a_reset_quiet: assert property (@(posedge clk)
    (!reset_n || $rose(reset_n)) |-> (!done_ai && !found))
    else begin
      fail_count++;
      $error("done_ai or found high during or right after reset");
    end

endmodule

/* source/ai_move_select.sv */
module ai_move_select (
  input  logic                                     clk,
  input  logic                                     reset_n,
  input  logic                                     start_ai,
  input  logic [tetris_ai_pkg::board_bits-1:0]     display_array,
  input  logic [2:0]                               piece_type,
  output logic [tetris_ai_pkg::move_id_width-1:0]  best_move_id,
  output logic signed [tetris_ai_pkg::q_width-1:0] best_q_value,
  output logic                                     found,
  output logic                                     done_ai
);

  logic [tetris_ai_pkg::board_bits-1:0]     board_q;
  logic [2:0]                               piece_q;
  logic [2:0]                               state_q;
  logic [tetris_ai_pkg::move_id_width-1:0]  move_q;   // Also the move id
  logic [1:0]                               rot_q;
  logic [3:0]                               col_q;

  logic                                     place_start;
  logic                                     place_done;
  logic                                     legal;
  logic [tetris_ai_pkg::board_bits-1:0]     placed_board;
  logic                                     extract_start;
  logic                                     extract_done;
  logic [tetris_ai_pkg::lines_width-1:0]    lines_cleared;
  logic [tetris_ai_pkg::feature_width-1:0]  holes;
  logic [tetris_ai_pkg::feature_width-1:0]  bumpiness;
  logic [tetris_ai_pkg::feature_width-1:0]  height_sum;
  logic                                     score_valid;
  logic signed [tetris_ai_pkg::q_width-1:0] q_value;
  logic                                     arg_start;
  logic                                     arg_finish;
  logic                                     arg_done;

  // ------------------------------------------------------------------
  // Candidate chain
  // ------------------------------------------------------------------
  placement_engine i_placement_engine (
    .clk          (clk),
    .reset_n      (reset_n),
    .place_start  (place_start),
    .piece_type   (piece_q),
    .rotation     (rot_q),
    .column       (col_q),
    .board        (board_q),
    .place_done   (place_done),
    .legal        (legal),
    .placed_board (placed_board)
  );

  feature_extract i_feature_extract (
    .clk           (clk),
    .reset_n       (reset_n),
    .extract_start (extract_start),
    .placed_board  (placed_board),
    .extract_done  (extract_done),
    .lines_cleared (lines_cleared),
    .holes         (holes),
    .bumpiness     (bumpiness),
    .height_sum    (height_sum)
  );

  q_scorer i_q_scorer (
    .clk           (clk),
    .reset_n       (reset_n),
    .score_start   (extract_done),  // Scores straight off the extractor
    .lines_cleared (lines_cleared),
    .holes         (holes),
    .bumpiness     (bumpiness),
    .height_sum    (height_sum),
    .score_valid   (score_valid),
    .q_value       (q_value)
  );

  argmax_unit i_argmax_unit (
    .clk          (clk),
    .reset_n      (reset_n),
    .arg_start    (arg_start),
    .valid        (score_valid),
    .q_value      (q_value),
    .move_id      (move_q),
    .arg_finish   (arg_finish),
    .arg_done     (arg_done),
    .best_move_id (best_move_id),
    .best_q_value (best_q_value),
    .found        (found)
  );

  // ------------------------------------------------------------------
  // Control FSM, one candidate at a time
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q       <= tetris_ai_pkg::ctl_idle;
      move_q        <= '0;
      rot_q         <= '0;
      col_q         <= '0;
      place_start   <= 1'b0;
      extract_start <= 1'b0;
      arg_start     <= 1'b0;
      arg_finish    <= 1'b0;
      done_ai       <= 1'b0;
    end else begin
      place_start   <= 1'b0;
      extract_start <= 1'b0;
      arg_start     <= 1'b0;
      arg_finish    <= 1'b0;
      done_ai       <= 1'b0;
      case (state_q)
        tetris_ai_pkg::ctl_idle: begin
          if (start_ai) begin
            move_q      <= '0;
            rot_q       <= '0;
            col_q       <= '0;
            arg_start   <= 1'b1;
            place_start <= 1'b1;
            state_q     <= tetris_ai_pkg::ctl_place;
          end
        end
        tetris_ai_pkg::ctl_place: begin
          if (place_done) begin
            if (legal) begin
              extract_start <= 1'b1;
              state_q       <= tetris_ai_pkg::ctl_extract;
            end else begin
              state_q <= tetris_ai_pkg::ctl_next;  // Skip scoring
            end
          end
        end
        tetris_ai_pkg::ctl_extract: begin
          if (extract_done) state_q <= tetris_ai_pkg::ctl_score;
        end
        tetris_ai_pkg::ctl_score: begin
          if (score_valid) state_q <= tetris_ai_pkg::ctl_next;  // Argmax takes it now
        end
        tetris_ai_pkg::ctl_next: begin
          if (move_q == tetris_ai_pkg::num_moves - 1) begin
            arg_finish <= 1'b1;
            state_q    <= tetris_ai_pkg::ctl_finish;
          end else begin
            move_q <= move_q + 1'b1;
            if (col_q == tetris_ai_pkg::board_cols - 1) begin
              col_q <= '0;
              rot_q <= rot_q + 1'b1;
            end else begin
              col_q <= col_q + 1'b1;
            end
            place_start <= 1'b1;
            state_q     <= tetris_ai_pkg::ctl_place;
          end
        end
        tetris_ai_pkg::ctl_finish: begin
          if (arg_done) begin
            done_ai <= 1'b1;
            state_q <= tetris_ai_pkg::ctl_idle;
          end
        end
        default: state_q <= tetris_ai_pkg::ctl_idle;
      endcase
    end
  end

  // Board and piece held for the whole run
  always_ff @(posedge clk) begin
    if (state_q == tetris_ai_pkg::ctl_idle && start_ai) begin
      board_q <= display_array;
      piece_q <= piece_type;
    end
  end

endmodule

/* source/argmax_unit.sv */
module argmax_unit (
  input  logic                                      clk,
  input  logic                                      reset_n,
  input  logic                                      arg_start,
  input  logic                                      valid,
  input  logic signed [tetris_ai_pkg::q_width-1:0]  q_value,
  input  logic [tetris_ai_pkg::move_id_width-1:0]   move_id,
  input  logic                                      arg_finish,
  output logic                                      arg_done,
  output logic [tetris_ai_pkg::move_id_width-1:0]   best_move_id,
  output logic signed [tetris_ai_pkg::q_width-1:0]  best_q_value,
  output logic                                      found
);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      arg_done     <= 1'b0;
      found        <= 1'b0;
      best_move_id <= tetris_ai_pkg::no_move_id;
      best_q_value <= tetris_ai_pkg::q_min;
    end else begin
      arg_done <= arg_finish;
      if (arg_start) begin  // Back to no result
        found        <= 1'b0;
        best_move_id <= tetris_ai_pkg::no_move_id;
        best_q_value <= tetris_ai_pkg::q_min;
      end else if (valid && (!found || q_value > best_q_value)) begin
        // Strictly greater, so the earlier (lower) id wins a tie
        found        <= 1'b1;
        best_move_id <= move_id;
        best_q_value <= q_value;
      end
    end
  end

endmodule

/* source/q_scorer.sv */
module q_scorer (
  input  logic                                    clk,
  input  logic                                    reset_n,
  input  logic                                    score_start,
  input  logic [tetris_ai_pkg::lines_width-1:0]   lines_cleared,
  input  logic [tetris_ai_pkg::feature_width-1:0] holes,
  input  logic [tetris_ai_pkg::feature_width-1:0] bumpiness,
  input  logic [tetris_ai_pkg::feature_width-1:0] height_sum,
  output logic                                    score_valid,
  output logic signed [tetris_ai_pkg::q_width-1:0] q_value
);

  int sum;

  // Features are unsigned, weights carry the sign
  always_comb begin
    sum = tetris_ai_pkg::weight_lines     * int'(lines_cleared)
        + tetris_ai_pkg::weight_holes     * int'(holes)
        + tetris_ai_pkg::weight_bumpiness * int'(bumpiness)
        + tetris_ai_pkg::weight_height    * int'(height_sum);
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      score_valid <= 1'b0;
    end else begin
      score_valid <= score_start;
    end
  end

  always_ff @(posedge clk) begin
    if (score_start) begin
      if (sum > tetris_ai_pkg::q_max)      q_value <= tetris_ai_pkg::q_max;
      else if (sum < tetris_ai_pkg::q_min) q_value <= tetris_ai_pkg::q_min;
      else                                 q_value <= sum[tetris_ai_pkg::q_width-1:0];
    end
  end

endmodule

/* source/feature_extract.sv */
module feature_extract (
  input  logic                                    clk,
  input  logic                                    reset_n,
  input  logic                                    extract_start,
  input  logic [tetris_ai_pkg::board_bits-1:0]    placed_board,
  output logic                                    extract_done,
  output logic [tetris_ai_pkg::lines_width-1:0]   lines_cleared,
  output logic [tetris_ai_pkg::feature_width-1:0] holes,
  output logic [tetris_ai_pkg::feature_width-1:0] bumpiness,
  output logic [tetris_ai_pkg::feature_width-1:0] height_sum
);

  logic [4:0] row_q;
  logic       busy_q;
  logic       total_q;     // Summing cycle after row 19
  logic [4:0] row_idx;
  logic [tetris_ai_pkg::board_cols-1:0] row_bits;
  logic [tetris_ai_pkg::board_cols-1:0] top_q;
  logic [tetris_ai_pkg::board_cols-1:0] top_n;
  logic [4:0] height_q [tetris_ai_pkg::board_cols];
  logic [4:0] height_n [tetris_ai_pkg::board_cols];
  logic [tetris_ai_pkg::feature_width-1:0] holes_n;
  logic [tetris_ai_pkg::lines_width-1:0]   lines_n;
  logic [tetris_ai_pkg::feature_width-1:0] bump_sum;
  logic [tetris_ai_pkg::feature_width-1:0] h_sum;

  // ------------------------------------------------------------------
  // Row step, start cycle handles row 0 from a cleared state
  // ------------------------------------------------------------------
  always_comb begin
    row_idx  = extract_start ? 5'd0 : row_q;
    row_bits = placed_board[row_idx*tetris_ai_pkg::board_cols +: tetris_ai_pkg::board_cols];
    top_n    = extract_start ? '0 : top_q;
    holes_n  = extract_start ? '0 : holes;
    lines_n  = extract_start ? '0 : lines_cleared;
    for (int c = 0; c < tetris_ai_pkg::board_cols; c++) begin
      height_n[c] = extract_start ? 5'd0 : height_q[c];
      if (row_bits[c] && !top_n[c]) begin  // First filled cell of column
        top_n[c]    = 1'b1;
        height_n[c] = 5'(tetris_ai_pkg::board_rows - row_idx);
      end else if (!row_bits[c] && top_n[c]) begin
        holes_n = holes_n + 1'b1;
      end
    end
    if (&row_bits && lines_n != '1) lines_n = lines_n + 1'b1;  // Saturates at 7
  end

  // Column totals
  always_comb begin
    h_sum    = {3'b000, height_q[0]};
    bump_sum = '0;
    for (int c = 1; c < tetris_ai_pkg::board_cols; c++) begin
      h_sum = h_sum + height_q[c];
      if (height_q[c] > height_q[c-1]) bump_sum = bump_sum + (height_q[c] - height_q[c-1]);
      else                             bump_sum = bump_sum + (height_q[c-1] - height_q[c]);
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      row_q        <= '0;
      busy_q       <= 1'b0;
      total_q      <= 1'b0;
      extract_done <= 1'b0;
    end else begin
      extract_done <= total_q;
      if (extract_start || busy_q) begin
        row_q   <= row_idx + 5'd1;
        busy_q  <= (row_idx != tetris_ai_pkg::board_rows - 1);
        total_q <= (row_idx == tetris_ai_pkg::board_rows - 1);
      end else begin
        total_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (extract_start || busy_q) begin
      top_q         <= top_n;
      height_q      <= height_n;
      holes         <= holes_n;
      lines_cleared <= lines_n;
    end
    if (total_q) begin
      bumpiness  <= bump_sum;
      height_sum <= h_sum;
    end
  end

endmodule

/* source/placement_engine.sv */
module placement_engine (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic                                 place_start,
  input  logic [2:0]                           piece_type,
  input  logic [1:0]                           rotation,
  input  logic [3:0]                           column,
  input  logic [tetris_ai_pkg::board_bits-1:0] board,
  output logic                                 place_done,
  output logic                                 legal,
  output logic [tetris_ai_pkg::board_bits-1:0] placed_board
);

  logic [4:0]  shape_idx;
  logic [15:0] mask_q;
  logic [3:0]  col_q;
  logic [4:0]  row_q;          // Board row under mask row 0
  logic        check_q;
  logic        drop_q;
  logic        out_of_bounds;
  logic        hit_spawn;
  logic        hit_below;

  // True when any mask cell is off the bottom or on a filled cell
  function automatic logic collides(input logic [15:0] m, input logic [4:0] r,
                                    input logic [3:0] c,
                                    input logic [tetris_ai_pkg::board_bits-1:0] b);
    int   br;
    int   bc;
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 16; i++) begin
      br = r + i / 4;
      bc = c + i % 4;
      if (m[i]) begin
        if (br >= tetris_ai_pkg::board_rows) begin
          hit = 1'b1;
        end else if (bc < tetris_ai_pkg::board_cols &&
                     b[br*tetris_ai_pkg::board_cols + bc]) begin
          hit = 1'b1;
        end
      end
    end
    return hit;
  endfunction

  // Mask moved to its board position
  function automatic logic [tetris_ai_pkg::board_bits-1:0] stamp(input logic [15:0] m,
                                                                 input logic [4:0]  r,
                                                                 input logic [3:0]  c);
    logic [tetris_ai_pkg::board_bits-1:0] w;
    int br;
    int bc;
    w = '0;
    for (int i = 0; i < 16; i++) begin
      br = r + i / 4;
      bc = c + i % 4;
      if (m[i] && br < tetris_ai_pkg::board_rows && bc < tetris_ai_pkg::board_cols) begin
        w[br*tetris_ai_pkg::board_cols + bc] = 1'b1;
      end
    end
    return w;
  endfunction

  assign shape_idx = {piece_type, rotation};
  assign hit_spawn = collides(mask_q, 5'd0, col_q, board);
  assign hit_below = collides(mask_q, row_q + 5'd1, col_q, board);

  always_comb begin
    out_of_bounds = 1'b0;
    for (int i = 0; i < 16; i++) begin
      if (mask_q[i] && (col_q + i % 4) >= tetris_ai_pkg::board_cols) out_of_bounds = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      check_q    <= 1'b0;
      drop_q     <= 1'b0;
      row_q      <= '0;
      place_done <= 1'b0;
      legal      <= 1'b0;
    end else begin
      place_done <= 1'b0;
      if (place_start) begin
        check_q <= 1'b1;
        drop_q  <= 1'b0;
        row_q   <= '0;
      end else if (check_q) begin
        check_q <= 1'b0;
        if (mask_q == '0 || out_of_bounds || hit_spawn) begin  // Unknown piece is illegal
          legal      <= 1'b0;
          place_done <= 1'b1;
        end else begin
          drop_q <= 1'b1;
        end
      end else if (drop_q) begin
        if (hit_below) begin  // Landed
          drop_q     <= 1'b0;
          legal      <= 1'b1;
          place_done <= 1'b1;
        end else begin
          row_q <= row_q + 5'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (place_start) begin
      mask_q <= (shape_idx < tetris_ai_pkg::num_pieces * tetris_ai_pkg::num_rotations) ?
                tetris_ai_pkg::shape_table[shape_idx] : '0;
      col_q  <= column;
    end
    if (drop_q && hit_below) placed_board <= board | stamp(mask_q, row_q, col_q);
  end

endmodule

/* source/tetris_ai_pkg.sv */
package tetris_ai_pkg;

  // ------------------------------------------------------------------
  // Board and move geometry
  // ------------------------------------------------------------------
  localparam int board_rows    = 20;  // Row 0 is the top
  localparam int board_cols    = 10;
  localparam int board_bits    = board_rows * board_cols;  // Bit r*10 + c
  localparam int num_pieces    = 7;
  localparam int num_rotations = 4;
  localparam int num_moves     = num_rotations * board_cols;

  // Move id is rotation*10 + column
  localparam int move_id_width = 6;
  localparam logic [move_id_width-1:0] no_move_id = '1;  // 63

  // Feature and score widths
  localparam int feature_width = 8;
  localparam int lines_width   = 3;
  localparam int q_width       = 18;
  localparam logic signed [q_width-1:0] q_max = {1'b0, {(q_width-1){1'b1}}};
  localparam logic signed [q_width-1:0] q_min = {1'b1, {(q_width-1){1'b0}}};

  // Linear scorer weights
  localparam int weight_lines     = 8;
  localparam int weight_holes     = -4;
  localparam int weight_bumpiness = -1;
  localparam int weight_height    = -2;

  // ------------------------------------------------------------------
  // Shape table, 4x4 masks, bit row*4 + col, row 0 on top
  // Index is piece_type*4 + rotation
  // ------------------------------------------------------------------
  localparam logic [0:num_pieces*num_rotations-1][15:0] shape_table = {
    16'h000F, 16'h1111, 16'h000F, 16'h1111,  // I
    16'h0033, 16'h0033, 16'h0033, 16'h0033,  // O
    16'h0027, 16'h0131, 16'h0072, 16'h0232,  // T
    16'h0036, 16'h0231, 16'h0036, 16'h0231,  // S
    16'h0063, 16'h0132, 16'h0063, 16'h0132,  // Z
    16'h0071, 16'h0113, 16'h0047, 16'h0322,  // J
    16'h0074, 16'h0311, 16'h0017, 16'h0223   // L
  };

  // Control FSM state codes
  localparam logic [2:0] ctl_idle    = 3'd0;
  localparam logic [2:0] ctl_place   = 3'd1;
  localparam logic [2:0] ctl_extract = 3'd2;
  localparam logic [2:0] ctl_score   = 3'd3;
  localparam logic [2:0] ctl_next    = 3'd4;
  localparam logic [2:0] ctl_finish  = 3'd5;

endpackage
